// ==== hdl/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    // ==========================================================================
    // Sizes of the line store and the request fields
    // ==========================================================================

    // Line address, 64 lines in the local store
    localparam int addr_width = 6;
    localparam int line_count = 1 << addr_width;

    // One cache line of payload
    localparam int data_width = 32;

    // Line count field, value plus one gives 1 to 4 lines
    localparam int len_width = 2;

    // Request tag carried in every header
    localparam int tag_width = 6;

    // ==========================================================================
    // Tag counter start values
    // ==========================================================================

    // Off-aligned on purpose so a stuck or skipped tag shows up quickly
    localparam logic [tag_width-1:0] read_tag_start  = tag_width'(27);
    localparam logic [tag_width-1:0] write_tag_start = tag_width'(13);

endpackage

// ==== hdl/mem_req_pkg.sv ====
package mem_req_pkg;

    // Request opcode, same bit position in both header views
    typedef enum logic [1:0]
    {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } mem_op_e;

    // Read view of the header word
    // Spare bit keeps both views the same width
    typedef struct packed
    {
        mem_op_e                              op;
        logic                                 spare;
        logic [mem_cfg_pkg::len_width-1:0]    num_lines;
        logic [mem_cfg_pkg::tag_width-1:0]    tag;
        logic [mem_cfg_pkg::addr_width-1:0]   addr;
    } mem_rd_hdr_t;

    // Write view of the header word
    typedef struct packed
    {
        mem_op_e                              op;
        logic                                 sop;
        logic [mem_cfg_pkg::len_width-1:0]    num_lines;
        logic [mem_cfg_pkg::tag_width-1:0]    tag;
        logic [mem_cfg_pkg::addr_width-1:0]   addr;
    } mem_wr_hdr_t;

    // One header word, decoded by opcode
    typedef union packed
    {
        mem_rd_hdr_t rd;
        mem_wr_hdr_t wr;
    } mem_hdr_u;

    // Burst sequencer state codes
    localparam logic [1:0] state_idle       = 2'd0;
    localparam logic [1:0] state_read_burst = 2'd1;
    localparam logic [1:0] state_write_open = 2'd2;

endpackage

// ==== hdl/mem_req_format.sv ====
`timescale 1ns/100ps

module mem_req_format
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Client read request
    input  logic [mem_cfg_pkg::addr_width-1:0]   read_req_addr,
    input  logic [mem_cfg_pkg::len_width-1:0]    read_req_num_lines,
    input  logic                                 read_req_enable,
    output logic                                 read_req_rdy,

    // Client write request
    input  logic [mem_cfg_pkg::addr_width-1:0]   write_addr,
    input  logic [mem_cfg_pkg::data_width-1:0]   write_data,
    input  logic [mem_cfg_pkg::len_width-1:0]    write_num_lines,
    input  logic                                 write_sop,
    input  logic                                 write_enable,
    output logic                                 write_rdy,

    // Sequencer status
    input  logic                                 busy,
    input  logic                                 wr_open,

    // Tags from the tracker
    input  logic [mem_cfg_pkg::tag_width-1:0]    read_tag,
    input  logic [mem_cfg_pkg::tag_width-1:0]    write_tag,

    // Registered header toward the sequencer
    output mem_req_pkg::mem_hdr_u                hdr,
    output logic                                 hdr_valid,
    output logic [mem_cfg_pkg::data_width-1:0]   hdr_data
);

    mem_req_pkg::mem_hdr_u hdr_next;

    // Reads wait out an issuing read burst and any open write burst
    assign read_req_rdy = !busy && !wr_open;
    // Write beats only blocked while reads are being issued
    assign write_rdy = !busy;

    // Header word for whichever enable is up
    always_comb
    begin
        hdr_next = '0;
        if (read_req_enable)
        begin
            hdr_next.rd.op        = mem_req_pkg::op_read;
            hdr_next.rd.num_lines = read_req_num_lines;
            hdr_next.rd.tag       = read_tag;
            hdr_next.rd.addr      = read_req_addr;
        end
        else if (write_enable)
        begin
            hdr_next.wr.op        = mem_req_pkg::op_write;
            hdr_next.wr.sop       = write_sop;
            hdr_next.wr.num_lines = write_num_lines;
            hdr_next.wr.tag       = write_tag;
            hdr_next.wr.addr      = write_addr;
        end
    end

    // Header strobe, one cycle per accepted request
    always_ff @(posedge clk)
    begin
        if (reset)
            hdr_valid <= 1'b0;
        else
            hdr_valid <= read_req_enable || write_enable;
    end

    // Header and payload hold until the next request
    always_ff @(posedge clk)
    begin
        if (read_req_enable || write_enable)
            hdr <= hdr_next;
        if (write_enable)
            hdr_data <= write_data;
    end

    // Client must respect the ready levels and never issue both at once
    a_read_rdy : assert property (@(posedge clk) disable iff (reset)
        read_req_enable |-> read_req_rdy)
        else $error("read_req_enable raised while read_req_rdy low");
    a_write_rdy : assert property (@(posedge clk) disable iff (reset)
        write_enable |-> write_rdy)
        else $error("write_enable raised while write_rdy low");
    a_one_enable : assert property (@(posedge clk) disable iff (reset)
        !(read_req_enable && write_enable))
        else $error("read and write enables high together");

endmodule

// ==== hdl/mem_tag_tracker.sv ====
`timescale 1ns/100ps

module mem_tag_tracker
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Client request strobes
    input  logic                                 read_req_enable,
    input  logic                                 write_enable,
    input  logic                                 write_sop,

    // Read responses from the store
    input  logic                                 read_rsp_valid,
    input  logic                                 read_rsp_eop,
    input  logic [mem_cfg_pkg::tag_width-1:0]    rsp_tag,

    output logic [mem_cfg_pkg::tag_width-1:0]    read_tag,
    output logic [mem_cfg_pkg::tag_width-1:0]    write_tag,
    output logic                                 tag_error
);

    logic [mem_cfg_pkg::tag_width-1:0] read_tag_q;
    logic [mem_cfg_pkg::tag_width-1:0] write_tag_q;
    logic [mem_cfg_pkg::tag_width-1:0] rsp_tag_q;
    logic                              tag_mismatch;

    assign read_tag = read_tag_q;
    // New tag already visible on the sop beat itself
    assign write_tag = write_tag_q
                     + mem_cfg_pkg::tag_width'(write_enable && write_sop);

    // Responses come back in order, so one expected tag per burst
    assign tag_mismatch = read_rsp_valid && (rsp_tag != rsp_tag_q);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_tag_q  <= mem_cfg_pkg::read_tag_start;
            write_tag_q <= mem_cfg_pkg::write_tag_start;
            rsp_tag_q   <= mem_cfg_pkg::read_tag_start;
            tag_error   <= 1'b0;
        end
        else
        begin
            write_tag_q <= write_tag;
            if (read_req_enable)
                read_tag_q <= read_tag_q + 1'b1;
            // Expected tag moves on once the burst ends
            if (read_rsp_valid && read_rsp_eop)
                rsp_tag_q <= rsp_tag_q + 1'b1;
            // Sticky until reset
            if (tag_mismatch)
                tag_error <= 1'b1;
        end
    end

    // Expected tag must belong to a read request already counted
    a_rsp_outstanding : assert property (@(posedge clk) disable iff (reset)
        read_rsp_valid |-> (rsp_tag_q != read_tag_q))
        else $error("read response with no read request outstanding");

endmodule

// ==== hdl/mem_burst_fsm.sv ====
`timescale 1ns/100ps

module mem_burst_fsm
(
    input  logic                                 clk,
    input  logic                                 reset,

    input  mem_req_pkg::mem_hdr_u                hdr,
    input  logic                                 hdr_valid,
    input  logic [mem_cfg_pkg::data_width-1:0]   hdr_data,

    output logic                                 busy,
    output logic                                 wr_open,

    // Per-line store access
    output logic [mem_cfg_pkg::addr_width-1:0]   st_addr,
    output logic [mem_cfg_pkg::data_width-1:0]   st_wdata,
    output logic                                 st_wr_en,
    output logic                                 st_rd_en,
    output logic [mem_cfg_pkg::tag_width-1:0]    st_tag,
    output logic                                 st_last
);

    logic [1:0]                         state_q;
    logic [mem_cfg_pkg::addr_width-1:0] addr_q;
    logic [mem_cfg_pkg::len_width-1:0]  cnt_q;
    logic [mem_cfg_pkg::tag_width-1:0]  tag_q;
    logic                               is_read;
    logic                               is_write;
    logic                               opens_burst;

    // Opcode first, then the matching view
    assign is_read  = hdr_valid && (hdr.rd.op == mem_req_pkg::op_read);
    assign is_write = hdr_valid && (hdr.wr.op == mem_req_pkg::op_write);
    assign opens_burst = is_write && hdr.wr.sop && (hdr.wr.num_lines != '0);

    // Busy covers the header cycle so ready drops right after the enable
    assign busy    = (state_q == mem_req_pkg::state_read_burst) || is_read;
    assign wr_open = (state_q == mem_req_pkg::state_write_open) || opens_burst;

    // ==========================================================================
    // Store access for this cycle
    // ==========================================================================

    always_comb
    begin
        st_addr  = hdr.rd.addr;
        st_tag   = hdr.rd.tag;
        st_wdata = hdr_data;
        st_rd_en = 1'b0;
        st_wr_en = 1'b0;
        st_last  = 1'b0;
        if (state_q == mem_req_pkg::state_read_burst)
        begin
            // Later beats of a read burst
            st_addr  = addr_q;
            st_tag   = tag_q;
            st_rd_en = 1'b1;
            st_last  = (cnt_q == '0);
        end
        else if (is_read)
        begin
            // First beat straight from the header
            st_rd_en = 1'b1;
            st_last  = (hdr.rd.num_lines == '0);
        end
        else if (is_write)
        begin
            st_addr  = hdr.wr.addr;
            st_tag   = hdr.wr.tag;
            st_wr_en = 1'b1;
        end
    end

    // ==========================================================================
    // State and burst counters
    // ==========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= mem_req_pkg::state_idle;
        else
        begin
            case (state_q)
                mem_req_pkg::state_idle:
                begin
                    if (is_read && (hdr.rd.num_lines != '0))
                        state_q <= mem_req_pkg::state_read_burst;
                    else if (opens_burst)
                        state_q <= mem_req_pkg::state_write_open;
                end
                mem_req_pkg::state_read_burst:
                begin
                    if (cnt_q == '0)
                        state_q <= mem_req_pkg::state_idle;
                end
                mem_req_pkg::state_write_open:
                begin
                    // Close on the last continuation beat
                    if (is_write && !hdr.wr.sop && (cnt_q == '0))
                        state_q <= mem_req_pkg::state_idle;
                end
                default:
                    state_q <= mem_req_pkg::state_idle;
            endcase
        end
    end

    // Counter holds beats left minus one
    always_ff @(posedge clk)
    begin
        if ((state_q == mem_req_pkg::state_idle) && is_read)
        begin
            addr_q <= hdr.rd.addr + 1'b1;
            cnt_q  <= hdr.rd.num_lines - 1'b1;
            tag_q  <= hdr.rd.tag;
        end
        else if (state_q == mem_req_pkg::state_read_burst)
        begin
            addr_q <= addr_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
        end
        else if (opens_burst)
            cnt_q <= hdr.wr.num_lines - 1'b1;
        else if ((state_q == mem_req_pkg::state_write_open) && is_write)
            cnt_q <= cnt_q - 1'b1;
    end

    // Continuation beats only belong inside an open burst
    a_wr_cont : assert property (@(posedge clk) disable iff (reset)
        (is_write && !hdr.wr.sop) |-> (state_q == mem_req_pkg::state_write_open))
        else $error("non-sop write beat with no open write burst");

endmodule

// ==== hdl/mem_line_store.sv ====
`timescale 1ns/100ps

module mem_line_store
(
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [mem_cfg_pkg::addr_width-1:0]   st_addr,
    input  logic [mem_cfg_pkg::data_width-1:0]   st_wdata,
    input  logic                                 st_wr_en,
    input  logic                                 st_rd_en,
    input  logic [mem_cfg_pkg::tag_width-1:0]    st_tag,
    input  logic                                 st_last,

    output logic [mem_cfg_pkg::data_width-1:0]   read_rsp_data,
    output logic                                 read_rsp_valid,
    output logic                                 read_rsp_eop,
    output logic [mem_cfg_pkg::tag_width-1:0]    rsp_tag,
    output logic                                 write_ack
);

    // Line array standing in for memory
    logic [mem_cfg_pkg::data_width-1:0] mem [mem_cfg_pkg::line_count];

    // Array write and registered read data with its tag
    always_ff @(posedge clk)
    begin
        if (st_wr_en)
            mem[st_addr] <= st_wdata;
        if (st_rd_en)
        begin
            read_rsp_data <= mem[st_addr];
            rsp_tag       <= st_tag;
        end
    end

    // Response strobes, one cycle behind the access
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_rsp_valid <= 1'b0;
            read_rsp_eop   <= 1'b0;
            write_ack      <= 1'b0;
        end
        else
        begin
            read_rsp_valid <= st_rd_en;
            read_rsp_eop   <= st_rd_en && st_last;
            write_ack      <= st_wr_en;
        end
    end

endmodule

// ==== hdl/mem_driver_top.sv ====
`timescale 1ns/100ps

module mem_driver_top
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Read request
    input  logic [mem_cfg_pkg::addr_width-1:0]   read_req_addr,
    input  logic [mem_cfg_pkg::len_width-1:0]    read_req_num_lines,
    input  logic                                 read_req_enable,
    output logic                                 read_req_rdy,

    // Read response
    output logic [mem_cfg_pkg::data_width-1:0]   read_rsp_data,
    output logic                                 read_rsp_valid,
    output logic                                 read_rsp_eop,

    // Write request
    input  logic [mem_cfg_pkg::addr_width-1:0]   write_addr,
    input  logic [mem_cfg_pkg::data_width-1:0]   write_data,
    input  logic [mem_cfg_pkg::len_width-1:0]    write_num_lines,
    input  logic                                 write_sop,
    input  logic                                 write_enable,
    output logic                                 write_rdy,

    output logic                                 write_ack,
    output logic                                 tag_error
);

    mem_req_pkg::mem_hdr_u              hdr;
    logic                               hdr_valid;
    logic [mem_cfg_pkg::data_width-1:0] hdr_data;
    logic                               busy;
    logic                               wr_open;
    logic [mem_cfg_pkg::tag_width-1:0]  read_tag;
    logic [mem_cfg_pkg::tag_width-1:0]  write_tag;
    logic [mem_cfg_pkg::tag_width-1:0]  rsp_tag;
    // Store access bus
    logic [mem_cfg_pkg::addr_width-1:0] st_addr;
    logic [mem_cfg_pkg::data_width-1:0] st_wdata;
    logic                               st_wr_en;
    logic                               st_rd_en;
    logic [mem_cfg_pkg::tag_width-1:0]  st_tag;
    logic                               st_last;

    // Client requests into header words
    mem_req_format u_format
    (
        .clk, .reset,
        .read_req_addr, .read_req_num_lines, .read_req_enable, .read_req_rdy,
        .write_addr, .write_data, .write_num_lines, .write_sop, .write_enable,
        .write_rdy, .busy, .wr_open, .read_tag, .write_tag,
        .hdr, .hdr_valid, .hdr_data
    );

    mem_tag_tracker u_tags
    (
        .clk, .reset,
        .read_req_enable, .write_enable, .write_sop,
        .read_rsp_valid, .read_rsp_eop, .rsp_tag,
        .read_tag, .write_tag, .tag_error
    );

    // Headers expanded into line accesses
    mem_burst_fsm u_fsm
    (
        .clk, .reset,
        .hdr, .hdr_valid, .hdr_data, .busy, .wr_open,
        .st_addr, .st_wdata, .st_wr_en, .st_rd_en, .st_tag, .st_last
    );

    mem_line_store u_store
    (
        .clk, .reset,
        .st_addr, .st_wdata, .st_wr_en, .st_rd_en, .st_tag, .st_last,
        .read_rsp_data, .read_rsp_valid, .read_rsp_eop, .rsp_tag, .write_ack
    );

endmodule

// ==== verif/tb_mem_driver.sv ====
`timescale 1ns/100ps

module tb_mem_driver;

    localparam int wait_limit = 64;

    logic                                 clk = 1'b0;
    logic                                 reset;
    logic [mem_cfg_pkg::addr_width-1:0]   read_req_addr;
    logic [mem_cfg_pkg::len_width-1:0]    read_req_num_lines;
    logic                                 read_req_enable;
    logic                                 read_req_rdy;
    logic [mem_cfg_pkg::data_width-1:0]   read_rsp_data;
    logic                                 read_rsp_valid;
    logic                                 read_rsp_eop;
    logic [mem_cfg_pkg::addr_width-1:0]   write_addr;
    logic [mem_cfg_pkg::data_width-1:0]   write_data;
    logic [mem_cfg_pkg::len_width-1:0]    write_num_lines;
    logic                                 write_sop;
    logic                                 write_enable;
    logic                                 write_rdy;
    logic                                 write_ack;
    logic                                 tag_error;

    // Line model updated as each write beat is driven
    logic [mem_cfg_pkg::data_width-1:0]   model [mem_cfg_pkg::line_count];
    // Expected read beats in issue order
    logic [mem_cfg_pkg::data_width-1:0]   exp_data_q [$];
    bit                                   exp_eop_q [$];
    int                                   beat_cyc_q [$];
    logic [mem_cfg_pkg::data_width-1:0]   exp_data;
    bit                                   exp_eop;

    integer seed = 32'h78ca486b;
    int     cycle = 0;
    int     issue_cyc;
    int     ack_count = 0;
    int     lines_written = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    mem_driver_top u_mem_driver_top
    (
        .clk, .reset,
        .read_req_addr, .read_req_num_lines, .read_req_enable, .read_req_rdy,
        .read_rsp_data, .read_rsp_valid, .read_rsp_eop,
        .write_addr, .write_data, .write_num_lines, .write_sop, .write_enable,
        .write_rdy, .write_ack, .tag_error
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Rising edge count read back at falling edges
    always @(posedge clk)
        cycle <= cycle + 1;

    // ==========================================================================
    // Reporting
    // ==========================================================================

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error: time %0t, %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error: time %0t, %s", $time, what);
        errors++;
    endtask

    // Sticky tag_error looked at once as each test closes
    task automatic end_test(input string name, input int err_start);
        if (tag_error !== 1'b0)
            report_mismatch("tag_error", 32'd0, 32'(tag_error));
        tests_run++;
        if (errors == err_start)
            $display("%s: passed", name);
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    // ==========================================================================
    // Response monitor
    // ==========================================================================

    // Sampled on the falling edge between DUT updates
    always @(negedge clk)
    begin
        if (!reset && write_ack === 1'b1)
            ack_count++;
        if (!reset && read_rsp_valid === 1'b1)
        begin
            beat_cyc_q.push_back(cycle);
            if (exp_data_q.size() == 0)
                report_failure("read response arrived with no read outstanding");
            else
            begin
                exp_data = exp_data_q.pop_front();
                exp_eop  = exp_eop_q.pop_front();
                if (read_rsp_data !== exp_data)
                    report_mismatch("read_rsp_data", exp_data, read_rsp_data);
                if (read_rsp_eop !== exp_eop)
                    report_mismatch("read_rsp_eop", 32'(exp_eop), 32'(read_rsp_eop));
            end
        end
    end

    // ==========================================================================
    // Client side drivers
    // ==========================================================================

    // Enable is low in the sampled cycle, so ready can only stay or rise
    task automatic wait_rdy(input bit for_read, output int low_cycles);
        int   waited;
        logic rdy;
        low_cycles = 0;
        waited = 0;
        @(negedge clk);
        rdy = for_read ? read_req_rdy : write_rdy;
        while (rdy !== 1'b1 && waited < wait_limit)
        begin
            low_cycles++;
            waited++;
            @(negedge clk);
            rdy = for_read ? read_req_rdy : write_rdy;
        end
        if (rdy !== 1'b1)
            report_failure(for_read ? "read_req_rdy stayed low" : "write_rdy stayed low");
    endtask

    task automatic write_line(input logic [mem_cfg_pkg::addr_width-1:0] addr,
                              input logic [mem_cfg_pkg::data_width-1:0] data,
                              input bit sop, input logic [mem_cfg_pkg::len_width-1:0] nl);
        int low;
        wait_rdy(1'b0, low);
        @(posedge clk);
        write_addr      <= addr;
        write_data      <= data;
        write_sop       <= sop;
        write_num_lines <= nl;
        write_enable    <= 1'b1;
        model[addr] = data;
        lines_written++;
        // Cycle in which the enable is high
        @(negedge clk);
        issue_cyc = cycle;
        @(posedge clk);
        write_enable <= 1'b0;
    endtask

    task automatic issue_read(input logic [mem_cfg_pkg::addr_width-1:0] addr,
                              input logic [mem_cfg_pkg::len_width-1:0] nl);
        int                                 low;
        int                                 i;
        logic [mem_cfg_pkg::addr_width-1:0] line;
        wait_rdy(1'b1, low);
        @(posedge clk);
        read_req_addr      <= addr;
        read_req_num_lines <= nl;
        read_req_enable    <= 1'b1;
        // Beat i reads addr plus i and wraps in the store
        for (i = 0; i <= int'(nl); i++)
        begin
            line = addr + mem_cfg_pkg::addr_width'(i);
            exp_data_q.push_back(model[line]);
            exp_eop_q.push_back(i == int'(nl));
        end
        @(negedge clk);
        issue_cyc = cycle;
        @(posedge clk);
        read_req_enable <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0)
        begin
            report_failure("read responses missing");
            exp_data_q.delete();
            exp_eop_q.delete();
        end
    endtask

    task automatic wait_acks(input int target);
        int waited;
        waited = 0;
        while (ack_count < target && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (ack_count < target)
            report_failure("write acknowledges missing");
    endtask

    // First beat two cycles after the enable and one per cycle after that
    task automatic check_beat_timing(input int n);
        int i;
        if (beat_cyc_q.size() != n)
            report_mismatch("read beat count", 32'(n), 32'(beat_cyc_q.size()));
        else
            for (i = 0; i < n; i++)
                if (beat_cyc_q[i] - issue_cyc != 2 + i)
                    report_mismatch("read_rsp_valid latency", 32'(2 + i),
                                    32'(beat_cyc_q[i] - issue_cyc));
    endtask

    function automatic logic [31:0] fill_word(input logic [mem_cfg_pkg::addr_width-1:0] a);
        return {2'b10, a, 2'b01, ~a, 2'b11, a ^ 6'h2a, 2'b00, a + 6'd17};
    endfunction

    // ==========================================================================
    // Directed tests
    // ==========================================================================

    task automatic test_reset();
        int err_start;
        err_start = errors;
        @(negedge clk);
        if (read_req_rdy !== 1'b1)
            report_mismatch("read_req_rdy", 32'd1, 32'(read_req_rdy));
        if (write_rdy !== 1'b1)
            report_mismatch("write_rdy", 32'd1, 32'(write_rdy));
        if (read_rsp_valid !== 1'b0)
            report_mismatch("read_rsp_valid", 32'd0, 32'(read_rsp_valid));
        if (read_rsp_eop !== 1'b0)
            report_mismatch("read_rsp_eop", 32'd0, 32'(read_rsp_eop));
        if (write_ack !== 1'b0)
            report_mismatch("write_ack", 32'd0, 32'(write_ack));
        end_test("reset_state", err_start);
    endtask

    task automatic test_single();
        int          err_start;
        int          waited;
        logic [31:0] d;
        err_start = errors;
        d = $random(seed);
        write_line(6'h05, d, 1'b1, 2'd0);
        waited = 0;
        @(negedge clk);
        while (write_ack !== 1'b1 && waited < wait_limit)
        begin
            waited++;
            @(negedge clk);
        end
        if (write_ack !== 1'b1)
            report_failure("write_ack never pulsed");
        else if (cycle - issue_cyc != 2)
            report_mismatch("write_ack latency", 32'd2, 32'(cycle - issue_cyc));
        beat_cyc_q.delete();
        issue_read(6'h05, 2'd0);
        wait_drain();
        check_beat_timing(1);
        end_test("single_line", err_start);
    endtask

    task automatic test_burst();
        int          err_start;
        int          ack_start;
        int          i;
        logic [31:0] d;
        err_start = errors;
        ack_start = ack_count;
        // sop on the first beat only
        for (i = 0; i < 4; i++)
        begin
            d = $random(seed);
            write_line(6'h20 + 6'(i), d, i == 0, 2'd3);
        end
        wait_acks(ack_start + 4);
        beat_cyc_q.delete();
        issue_read(6'h20, 2'd3);
        wait_drain();
        check_beat_timing(4);
        end_test("multi_line_burst", err_start);
    endtask

    task automatic test_backpressure();
        int          err_start;
        int          low;
        int          i;
        logic [31:0] d;
        err_start = errors;
        for (i = 0; i < 4; i++)
        begin
            d = $random(seed);
            write_line(6'h30 + 6'(i), d, i == 0, 2'd3);
            @(negedge clk);
            // Burst still open before its fourth beat
            if (i < 3 && read_req_rdy !== 1'b0)
                report_mismatch("read_req_rdy", 32'd0, 32'(read_req_rdy));
        end
        wait_rdy(1'b1, low);
        // Ready back in the cycle right after the last beat
        if (low != 0)
            report_mismatch("read_req_rdy low cycles", 32'd0, 32'(low));
        issue_read(6'h30, 2'd3);
        // One low cycle per line issued
        wait_rdy(1'b0, low);
        if (low != 4)
            report_mismatch("write_rdy low cycles", 32'd4, 32'(low));
        d = $random(seed);
        write_line(6'h31, d, 1'b1, 2'd0);
        issue_read(6'h30, 2'd1);
        wait_drain();
        end_test("back_pressure", err_start);
    endtask

    task automatic test_random();
        int                                 err_start;
        int                                 n;
        int                                 i;
        logic [31:0]                        r;
        logic [31:0]                        d;
        logic [mem_cfg_pkg::len_width-1:0]  nl;
        err_start = errors;
        // Whole store written first so every read has a known value
        for (i = 0; i < mem_cfg_pkg::line_count; i++)
            write_line(6'(i), fill_word(6'(i)), (i % 4) == 0, 2'd3);
        for (n = 0; n < 24; n++)
        begin
            r = $random(seed);
            nl = r[9:8];
            if (r[16])
            begin
                for (i = 0; i <= int'(nl); i++)
                begin
                    d = $random(seed);
                    write_line(r[5:0] + 6'(i), d, i == 0, nl);
                end
            end
            else
                issue_read(r[5:0], nl);
        end
        wait_drain();
        wait_acks(lines_written);
        if (ack_count != lines_written)
            report_mismatch("write_ack count", 32'(lines_written), 32'(ack_count));
        end_test("random_traffic", err_start);
    endtask

    // ==========================================================================
    // Sequence
    // ==========================================================================

    initial
    begin
        reset              = 1'b1;
        read_req_addr      = '0;
        read_req_num_lines = '0;
        read_req_enable    = 1'b0;
        write_addr         = '0;
        write_data         = '0;
        write_num_lines    = '0;
        write_sop          = 1'b0;
        write_enable       = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_single();
        test_burst();
        test_backpressure();
        test_random();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/mem_cfg_pkg.sv
hdl/mem_req_pkg.sv
hdl/mem_req_format.sv
hdl/mem_tag_tracker.sv
hdl/mem_burst_fsm.sv
hdl/mem_line_store.sv
hdl/mem_driver_top.sv
verif/tb_mem_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_driver -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
